// File: compile.f
common/exec_pkg.sv
common/fu_if.sv
rtl/exec_ctrl.sv
rtl/fu_alu.sv
rtl/fu_mult.sv
rtl/fu_branch.sv
rtl/fu_agu.sv
rtl/execute_top.sv
test/tb_execute.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_execute \
    -f compile.f -o tb_execute > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_execute > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
    exit 0
fi
exit 1

// File: test/tb_execute.sv
`timescale 1ns/1ps

module tb_execute
    import exec_pkg::*;
();

    localparam int half_period  = 4;
    localparam int sample_delay = 2;
    // roughly 90 test cycles plus a wide margin
    localparam int watchdog_cycles = 2000;

    typedef struct {
        int          due;
        logic [31:0] rd_v;
        logic [16:0] tags;
        logic [31:0] inst;
    } mul_exp_t;

    logic clk;
    logic rst;
    logic [xlen-1:0] rs1_v_add, rs2_v_add, rs1_v_mul, rs2_v_mul;
    logic [xlen-1:0] rs1_v_br, rs2_v_br, rs1_v_mem, rs2_v_mem;
    decode_info_t decode_info_add, decode_info_mul, decode_info_br, decode_info_mem;
    logic start_add, start_mul, start_br, start_mem;
    logic [rob_idx_bits-1:0] rob_idx_add, rob_idx_mul, rob_idx_br;
    logic [phys_reg_bits-1:0] pd_add, pd_mul, pd_br;
    logic [arch_reg_bits-1:0] rd_add, rd_mul, rd_br;
    logic [lsq_idx_bits-1:0] mem_idx_in, mem_idx_out;
    cdb_t cdb_add, cdb_mul, cdb_br;
    logic addr_valid;
    logic [xlen-1:0] calculated_address, store_wdata;

    mul_exp_t mul_queue[$];
    logic [15:0] lfsr;
    int errors;
    int cyc;

    execute_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    // one lfsr step per bit
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic rand_tags(output logic [5:0] rob, output logic [5:0] pd, output logic [4:0] rd);
        logic [31:0] v;
        rand_bits(17, v);
        rob = v[16:11];
        pd = v[10:5];
        rd = v[4:0];
    endtask

    function automatic logic [31:0] sext12(input logic [31:0] r);
        return {{20{r[11]}}, r[11:0]};
    endfunction

    function automatic decode_info_t make_info(input exec_op_t op, input logic [31:0] imm,
                                               input logic [31:0] pc, input logic use_imm,
                                               input logic [31:0] inst);
        decode_info_t d;
        d.op = op;
        d.imm = imm;
        d.pc = pc;
        d.use_imm = use_imm;
        d.inst = inst;
        return d;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // rv32i integer semantics
    function automatic logic [31:0] alu_model(input exec_op_t op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sltu: return (a < b) ? 32'd1 : 32'd0;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_sra:  return $signed(a) >>> b[4:0];
            default: return 32'd0;
        endcase
    endfunction

    // 64-bit products with the high word picked per signedness
    function automatic logic [31:0] mul_model(input exec_op_t op, input logic [31:0] a,
                                              input logic [31:0] b);
        longint sa;
        longint sb;
        logic [63:0] p;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (op)
            op_mulh:   p = sa * sb;
            op_mulhsu: p = sa * longint'({32'b0, b});
            default:   p = {32'b0, a} * {32'b0, b};
        endcase
        return (op == op_mul) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic branch_taken(input exec_op_t op, input logic [31:0] a,
                                          input logic [31:0] b);
        case (op)
            op_beq:  return a == b;
            op_bne:  return a != b;
            op_blt:  return $signed(a) < $signed(b);
            op_bge:  return $signed(a) >= $signed(b);
            op_bltu: return a < b;
            op_bgeu: return a >= b;
            op_jal:  return 1'b1;
            op_jalr: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic cycle_begin();
        @(negedge clk);
        cyc++;
        start_add = 1'b0;
        start_mul = 1'b0;
        start_br = 1'b0;
        start_mem = 1'b0;
    endtask

    // every cycle the multiplier record is either due or idle
    task automatic cycle_sample(input string name);
        #sample_delay;
        if (mul_queue.size() > 0 && mul_queue[0].due == cyc) begin
            check({name, " mul valid"}, 32'd1, 32'(cdb_mul.valid));
            check({name, " mul rd_v"}, mul_queue[0].rd_v, cdb_mul.rd_v);
            check({name, " mul tags"}, 32'(mul_queue[0].tags),
                  32'({cdb_mul.rob_idx, cdb_mul.pd, cdb_mul.rd}));
            check({name, " mul inst"}, mul_queue[0].inst, cdb_mul.inst);
            check({name, " mul pc_select"}, 32'd0, 32'(cdb_mul.pc_select));
            check({name, " mul pc_branch"}, 32'd0, cdb_mul.pc_branch);
            void'(mul_queue.pop_front());
        end else begin
            check({name, " mul idle"}, 32'd0, 32'(cdb_mul.valid));
        end
    endtask

    task automatic issue_alu(input exec_op_t op, input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] imm, input logic use_imm);
        logic [31:0] inst;
        rand_bits(32, inst);
        rand_tags(rob_idx_add, pd_add, rd_add);
        rs1_v_add = a;
        rs2_v_add = b;
        decode_info_add = make_info(op, imm, 32'h0, use_imm, inst);
        start_add = 1'b1;
    endtask

    task automatic expect_alu(input string name);
        logic [31:0] b;
        b = decode_info_add.use_imm ? decode_info_add.imm : rs2_v_add;
        check({name, " valid"}, 32'd1, 32'(cdb_add.valid));
        check({name, " rd_v"}, alu_model(decode_info_add.op, rs1_v_add, b), cdb_add.rd_v);
        check({name, " tags"}, 32'({rob_idx_add, pd_add, rd_add}),
              32'({cdb_add.rob_idx, cdb_add.pd, cdb_add.rd}));
        check({name, " inst"}, decode_info_add.inst, cdb_add.inst);
        check({name, " pc_select"}, 32'd0, 32'(cdb_add.pc_select));
        check({name, " pc_branch"}, 32'd0, cdb_add.pc_branch);
    endtask

    task automatic issue_mul(input exec_op_t op, input logic [31:0] a, input logic [31:0] b);
        mul_exp_t e;
        logic [31:0] inst;
        rand_bits(32, inst);
        rand_tags(rob_idx_mul, pd_mul, rd_mul);
        // distinct rob slot per start
        rob_idx_mul = 6'(cyc);
        rs1_v_mul = a;
        rs2_v_mul = b;
        decode_info_mul = make_info(op, 32'h0, 32'h0, 1'b0, inst);
        start_mul = 1'b1;
        e.due = cyc + mult_latency;
        e.rd_v = mul_model(op, a, b);
        e.tags = {rob_idx_mul, pd_mul, rd_mul};
        e.inst = inst;
        mul_queue.push_back(e);
    endtask

    task automatic issue_br(input exec_op_t op, input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] pc, input logic [31:0] imm);
        logic [31:0] inst;
        rand_bits(32, inst);
        rand_tags(rob_idx_br, pd_br, rd_br);
        rs1_v_br = a;
        rs2_v_br = b;
        decode_info_br = make_info(op, imm, pc, 1'b0, inst);
        start_br = 1'b1;
    endtask

    task automatic expect_br(input string name);
        exec_op_t op;
        logic jump;
        logic [31:0] target;
        op = decode_info_br.op;
        jump = (op == op_jal) || (op == op_jalr);
        if (op == op_jalr) begin
            target = (rs1_v_br + decode_info_br.imm) & ~32'd1;
        end else begin
            target = decode_info_br.pc + decode_info_br.imm;
        end
        check({name, " valid"}, 32'd1, 32'(cdb_br.valid));
        check({name, " pc_select"}, 32'(branch_taken(op, rs1_v_br, rs2_v_br)),
              32'(cdb_br.pc_select));
        check({name, " pc_branch"}, target, cdb_br.pc_branch);
        check({name, " rd_v"}, jump ? decode_info_br.pc + 32'd4 : 32'd0, cdb_br.rd_v);
        check({name, " tags"}, 32'({rob_idx_br, pd_br, rd_br}),
              32'({cdb_br.rob_idx, cdb_br.pd, cdb_br.rd}));
        check({name, " inst"}, decode_info_br.inst, cdb_br.inst);
    endtask

    task automatic issue_mem(input exec_op_t op, input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] imm);
        logic [31:0] v;
        rand_bits(6, v);
        mem_idx_in = v[5:0];
        rs1_v_mem = a;
        rs2_v_mem = b;
        decode_info_mem = make_info(op, imm, 32'h0, 1'b0, 32'h0);
        start_mem = 1'b1;
    endtask

    task automatic expect_mem(input string name);
        check({name, " addr_valid"}, 32'd1, 32'(addr_valid));
        check({name, " address"}, rs1_v_mem + decode_info_mem.imm, calculated_address);
        check({name, " store_wdata"}, (decode_info_mem.op == op_store) ? rs2_v_mem : 32'd0,
              store_wdata);
        check({name, " mem_idx"}, 32'(mem_idx_in), 32'(mem_idx_out));
    endtask

    task automatic test_reset_idle();
        cycle_begin();
        cycle_sample("reset");
        check("reset add valid", 32'd0, 32'(cdb_add.valid));
        check("reset br valid", 32'd0, 32'(cdb_br.valid));
        check("reset addr_valid", 32'd0, 32'(addr_valid));
    endtask

    task automatic test_alu();
        exec_op_t ops[10] = '{op_add, op_sub, op_and, op_or, op_xor,
                              op_slt, op_sltu, op_sll, op_srl, op_sra};
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        foreach (ops[i]) begin
            for (int u = 0; u < 2; u++) begin
                cycle_begin();
                rand_bits(32, a);
                rand_bits(32, b);
                rand_bits(12, r);
                issue_alu(ops[i], a, b, sext12(r), u[0]);
                cycle_sample("alu");
                expect_alu($sformatf("alu %s use_imm=%0d", ops[i].name(), u));
            end
        end
    endtask

    task automatic test_mul();
        exec_op_t ops[4] = '{op_mul, op_mulh, op_mulhsu, op_mulhu};
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 5 + mult_latency + 2; i++) begin
            cycle_begin();
            if (i < 5) begin
                rand_bits(32, a);
                rand_bits(32, b);
                issue_mul(ops[i % 4], a, b);
            end
            cycle_sample($sformatf("mul cycle %0d", i));
        end
    endtask

    task automatic test_branch();
        exec_op_t ops[8] = '{op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu, op_jal, op_jalr};
        logic [31:0] pa[5];
        logic [31:0] pb[5];
        logic [31:0] x;
        logic [31:0] pc;
        logic [31:0] r;
        rand_bits(32, x);
        // equal, less, greater and sign-crossing pairs
        pa = '{x, x, x + 32'd1, 32'h8000_0000, 32'h1};
        pb = '{x, x + 32'd1, x, 32'h1, 32'h8000_0000};
        foreach (ops[i]) begin
            for (int j = 0; j < 5; j++) begin
                cycle_begin();
                rand_bits(32, pc);
                rand_bits(12, r);
                // odd jalr base so the target has bit 0 to clear
                issue_br(ops[i], (ops[i] == op_jalr) ? pa[j] | 32'd1 : pa[j], pb[j],
                         pc & ~32'd3, sext12(r) & ~32'd1);
                cycle_sample("branch");
                expect_br($sformatf("branch %s pair %0d", ops[i].name(), j));
            end
        end
    endtask

    task automatic test_agu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] imm;
        for (int i = 0; i < 8; i++) begin
            cycle_begin();
            rand_bits(32, a);
            rand_bits(32, b);
            rand_bits(11, r);
            imm = i[1] ? -{21'b0, r[10:0]} : {21'b0, r[10:0]};
            issue_mem(i[0] ? op_store : op_load, a, b, imm);
            cycle_sample("agu");
            expect_mem($sformatf("agu %s imm=%0d", i[0] ? "store" : "load", $signed(imm)));
        end
    endtask

    task automatic test_parallel();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        cycle_begin();
        rand_bits(32, a);
        rand_bits(32, b);
        rand_bits(12, r);
        issue_alu(op_sub, a, b, 32'h0, 1'b0);
        issue_br(op_bne, a, b, r & ~32'd3, sext12(r) & ~32'd1);
        issue_mem(op_store, b, a, sext12(r));
        issue_mul(op_mulhsu, a, b);
        cycle_sample("parallel");
        expect_alu("parallel alu");
        expect_br("parallel branch");
        expect_mem("parallel agu");
        repeat (mult_latency + 1) begin
            cycle_begin();
            cycle_sample("parallel drain");
        end
    endtask

    initial begin
        errors = 0;
        cyc = 0;
        lfsr = 16'd16078;
        rst = 1'b1;
        rs1_v_add = '0;
        rs2_v_add = '0;
        rs1_v_mul = '0;
        rs2_v_mul = '0;
        rs1_v_br = '0;
        rs2_v_br = '0;
        rs1_v_mem = '0;
        rs2_v_mem = '0;
        decode_info_add = '0;
        decode_info_mul = '0;
        decode_info_br = '0;
        decode_info_mem = '0;
        start_add = 1'b0;
        start_mul = 1'b0;
        start_br = 1'b0;
        start_mem = 1'b0;
        rob_idx_add = '0;
        rob_idx_mul = '0;
        rob_idx_br = '0;
        pd_add = '0;
        pd_mul = '0;
        pd_br = '0;
        rd_add = '0;
        rd_mul = '0;
        rd_br = '0;
        mem_idx_in = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_idle();
        test_alu();
        test_mul();
        test_branch();
        test_agu();
        test_parallel();

        if (mul_queue.size() != 0) begin
            errors++;
            $display("multiplier results still pending at the end of the run");
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: rtl/execute_top.sv
`timescale 1ns/1ps

module execute_top
    import exec_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic [xlen-1:0]           rs1_v_add,
    input  logic [xlen-1:0]           rs2_v_add,
    input  decode_info_t              decode_info_add,
    input  logic                      start_add,
    input  logic [rob_idx_bits-1:0]   rob_idx_add,
    input  logic [phys_reg_bits-1:0]  pd_add,
    input  logic [arch_reg_bits-1:0]  rd_add,

    input  logic [xlen-1:0]           rs1_v_mul,
    input  logic [xlen-1:0]           rs2_v_mul,
    input  decode_info_t              decode_info_mul,
    input  logic                      start_mul,
    input  logic [rob_idx_bits-1:0]   rob_idx_mul,
    input  logic [phys_reg_bits-1:0]  pd_mul,
    input  logic [arch_reg_bits-1:0]  rd_mul,

    input  logic [xlen-1:0]           rs1_v_br,
    input  logic [xlen-1:0]           rs2_v_br,
    input  decode_info_t              decode_info_br,
    input  logic                      start_br,
    input  logic [rob_idx_bits-1:0]   rob_idx_br,
    input  logic [phys_reg_bits-1:0]  pd_br,
    input  logic [arch_reg_bits-1:0]  rd_br,

    input  logic [xlen-1:0]           rs1_v_mem,
    input  logic [xlen-1:0]           rs2_v_mem,
    input  decode_info_t              decode_info_mem,
    input  logic                      start_mem,
    input  logic [lsq_idx_bits-1:0]   mem_idx_in,

    output cdb_t                      cdb_add,
    output cdb_t                      cdb_mul,
    output cdb_t                      cdb_br,

    output logic                      addr_valid,
    output logic [xlen-1:0]           calculated_address,
    output logic [xlen-1:0]           store_wdata,
    output logic [lsq_idx_bits-1:0]   mem_idx_out
);

    logic            pc_select;
    logic [xlen-1:0] pc_branch;

    fu_if alu_bus ();
    fu_if mul_bus ();
    fu_if br_bus ();
    fu_if agu_bus ();

    exec_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .rs1_v_add(rs1_v_add), .rs2_v_add(rs2_v_add), .decode_info_add(decode_info_add),
        .start_add(start_add), .rob_idx_add(rob_idx_add), .pd_add(pd_add), .rd_add(rd_add),
        .rs1_v_mul(rs1_v_mul), .rs2_v_mul(rs2_v_mul), .decode_info_mul(decode_info_mul),
        .start_mul(start_mul), .rob_idx_mul(rob_idx_mul), .pd_mul(pd_mul), .rd_mul(rd_mul),
        .rs1_v_br(rs1_v_br), .rs2_v_br(rs2_v_br), .decode_info_br(decode_info_br),
        .start_br(start_br), .rob_idx_br(rob_idx_br), .pd_br(pd_br), .rd_br(rd_br),
        .alu_bus(alu_bus), .mul_bus(mul_bus), .br_bus(br_bus),
        .pc_select(pc_select), .pc_branch(pc_branch),
        .cdb_add(cdb_add), .cdb_mul(cdb_mul), .cdb_br(cdb_br)
    );

    fu_alu u_alu (.alu_bus(alu_bus));

    fu_mult u_mult (.clk(clk), .rst(rst), .mul_bus(mul_bus));

    fu_branch u_branch (.br_bus(br_bus), .pc_select(pc_select), .pc_branch(pc_branch));

    // address path rides agu_bus, the address comes back on rd_v
    assign agu_bus.start = start_mem;
    assign agu_bus.rs1_v = rs1_v_mem;
    assign agu_bus.rs2_v = rs2_v_mem;
    assign agu_bus.info  = decode_info_mem;

    fu_agu u_agu (
        .rs1_v(agu_bus.rs1_v), .rs2_v(agu_bus.rs2_v), .info(agu_bus.info),
        .start(agu_bus.start), .mem_idx_in(mem_idx_in),
        .addr_valid(agu_bus.valid), .calculated_address(agu_bus.rd_v),
        .store_wdata(store_wdata), .mem_idx_out(mem_idx_out)
    );

    assign addr_valid         = agu_bus.valid;
    assign calculated_address = agu_bus.rd_v;

endmodule

// File: rtl/fu_agu.sv
`timescale 1ns/1ps

module fu_agu
    import exec_pkg::*;
(
    input  logic [xlen-1:0]         rs1_v,
    input  logic [xlen-1:0]         rs2_v,
    input  decode_info_t            info,
    input  logic                    start,
    input  logic [lsq_idx_bits-1:0] mem_idx_in,
    output logic                    addr_valid,
    output logic [xlen-1:0]         calculated_address,
    output logic [xlen-1:0]         store_wdata,
    output logic [lsq_idx_bits-1:0] mem_idx_out
);

    // base plus sign extended offset
    assign calculated_address = rs1_v + info.imm;

    // loads carry no data
    assign store_wdata = (info.op == op_store) ? rs2_v : '0;

    assign addr_valid = start;

    // queue slot goes out with its address
    assign mem_idx_out = mem_idx_in;

endmodule

// File: rtl/fu_branch.sv
`timescale 1ns/1ps

module fu_branch
    import exec_pkg::*;
(
    fu_if.unit              br_bus,
    output logic            pc_select,
    output logic [xlen-1:0] pc_branch
);

    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic            taken;
    logic            is_jump;
    logic [xlen-1:0] jalr_target;

    assign rs1 = br_bus.rs1_v;
    assign rs2 = br_bus.rs2_v;

    always_comb begin
        case (br_bus.info.op)
            op_beq:  taken = (rs1 == rs2);
            op_bne:  taken = (rs1 != rs2);
            op_blt:  taken = ($signed(rs1) < $signed(rs2));
            op_bge:  taken = ($signed(rs1) >= $signed(rs2));
            op_bltu: taken = (rs1 < rs2);
            op_bgeu: taken = (rs1 >= rs2);
            default: taken = 1'b0;
        endcase
    end

    assign is_jump = (br_bus.info.op == op_jal) || (br_bus.info.op == op_jalr);

    // jalr target drops bit 0
    assign jalr_target = (rs1 + br_bus.info.imm) & ~32'd1;

    assign pc_branch = (br_bus.info.op == op_jalr) ? jalr_target
                                                   : br_bus.info.pc + br_bus.info.imm;
    assign pc_select = br_bus.start && (taken || is_jump);

    // link value only for jumps
    assign br_bus.rd_v  = is_jump ? br_bus.info.pc + 32'd4 : '0;
    assign br_bus.valid = br_bus.start;

endmodule

// File: rtl/fu_mult.sv
`timescale 1ns/1ps

module fu_mult
    import exec_pkg::*;
(
    input  logic clk,
    input  logic rst,
    fu_if.unit   mul_bus
);

    // stage 1: captured operands
    logic [xlen-1:0]          s1_a;
    logic [xlen-1:0]          s1_b;
    exec_op_t                 s1_op;
    logic                     s1_v;
    logic signed [xlen:0]     a_ext;
    logic signed [xlen:0]     b_ext;

    // stage 2: full product
    logic signed [2*xlen+1:0] s2_prod;
    exec_op_t                 s2_op;
    logic                     s2_v;

    // stages 3 and 4: selected half
    logic [xlen-1:0]          s3_res;
    logic                     s3_v;
    logic [xlen-1:0]          s4_res;
    logic                     s4_v;

    // mulhu and the rs2 side of mulhsu are zero extended
    assign a_ext = {(s1_op == op_mulh || s1_op == op_mulhsu) & s1_a[xlen-1], s1_a};
    assign b_ext = {(s1_op == op_mulh) & s1_b[xlen-1], s1_b};

    always_ff @(posedge clk) begin
        s1_a    <= mul_bus.rs1_v;
        s1_b    <= mul_bus.rs2_v;
        s1_op   <= mul_bus.info.op;
        s2_prod <= a_ext * b_ext;
        s2_op   <= s1_op;
        s3_res  <= (s2_op == op_mul) ? s2_prod[xlen-1:0] : s2_prod[2*xlen-1:xlen];
        s4_res  <= s3_res;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_v <= 1'b0;
            s2_v <= 1'b0;
            s3_v <= 1'b0;
            s4_v <= 1'b0;
        end else begin
            s1_v <= mul_bus.start;
            s2_v <= s1_v;
            s3_v <= s2_v;
            s4_v <= s3_v;
        end
    end

    assign mul_bus.rd_v  = s4_res;
    assign mul_bus.valid = s4_v;

    a_fixed_latency: assert property (
        @(posedge clk) disable iff (rst) mul_bus.valid == $past(mul_bus.start, mult_latency)
    );

endmodule

// File: rtl/fu_alu.sv
`timescale 1ns/1ps

module fu_alu
    import exec_pkg::*;
(
    fu_if.unit alu_bus
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] result;

    assign op_a  = alu_bus.rs1_v;
    assign op_b  = alu_bus.info.use_imm ? alu_bus.info.imm : alu_bus.rs2_v;
    // rv32 shifts only look at the low five bits
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_bus.info.op)
            op_add:  result = op_a + op_b;
            op_sub:  result = op_a - op_b;
            op_and:  result = op_a & op_b;
            op_or:   result = op_a | op_b;
            op_xor:  result = op_a ^ op_b;
            op_slt:  result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            op_sltu: result = {{(xlen-1){1'b0}}, op_a < op_b};
            op_sll:  result = op_a << shamt;
            op_srl:  result = op_a >> shamt;
            op_sra:  result = $unsigned($signed(op_a) >>> shamt);
            default: result = '0;
        endcase
    end

    // single cycle, result belongs to the current start
    assign alu_bus.rd_v  = result;
    assign alu_bus.valid = alu_bus.start;

endmodule

// File: rtl/exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl
    import exec_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic [xlen-1:0]           rs1_v_add,
    input  logic [xlen-1:0]           rs2_v_add,
    input  decode_info_t              decode_info_add,
    input  logic                      start_add,
    input  logic [rob_idx_bits-1:0]   rob_idx_add,
    input  logic [phys_reg_bits-1:0]  pd_add,
    input  logic [arch_reg_bits-1:0]  rd_add,

    input  logic [xlen-1:0]           rs1_v_mul,
    input  logic [xlen-1:0]           rs2_v_mul,
    input  decode_info_t              decode_info_mul,
    input  logic                      start_mul,
    input  logic [rob_idx_bits-1:0]   rob_idx_mul,
    input  logic [phys_reg_bits-1:0]  pd_mul,
    input  logic [arch_reg_bits-1:0]  rd_mul,

    input  logic [xlen-1:0]           rs1_v_br,
    input  logic [xlen-1:0]           rs2_v_br,
    input  decode_info_t              decode_info_br,
    input  logic                      start_br,
    input  logic [rob_idx_bits-1:0]   rob_idx_br,
    input  logic [phys_reg_bits-1:0]  pd_br,
    input  logic [arch_reg_bits-1:0]  rd_br,

    fu_if.ctrl                        alu_bus,
    fu_if.ctrl                        mul_bus,
    fu_if.ctrl                        br_bus,

    input  logic                      pc_select,
    input  logic [xlen-1:0]           pc_branch,

    output cdb_t                      cdb_add,
    output cdb_t                      cdb_mul,
    output cdb_t                      cdb_br
);

    // what the multiplier result needs to find its rob entry again
    typedef struct packed {
        logic [rob_idx_bits-1:0]   rob_idx;
        logic [phys_reg_bits-1:0]  pd;
        logic [arch_reg_bits-1:0]  rd;
        logic [inst_bits-1:0]      inst;
    } mul_tag_t;

    mul_tag_t [mult_latency-1:0] tag_pipe;
    mul_tag_t                    tag_in;
    mul_tag_t                    tag_out;

    // operand routing
    assign alu_bus.start = start_add;
    assign alu_bus.rs1_v = rs1_v_add;
    assign alu_bus.rs2_v = rs2_v_add;
    assign alu_bus.info  = decode_info_add;

    assign mul_bus.start = start_mul;
    assign mul_bus.rs1_v = rs1_v_mul;
    assign mul_bus.rs2_v = rs2_v_mul;
    assign mul_bus.info  = decode_info_mul;

    assign br_bus.start  = start_br;
    assign br_bus.rs1_v  = rs1_v_br;
    assign br_bus.rs2_v  = rs2_v_br;
    assign br_bus.info   = decode_info_br;

    // empty slot when no multiply was issued this cycle
    assign tag_in  = start_mul ? {rob_idx_mul, pd_mul, rd_mul, decode_info_mul.inst} : '0;
    assign tag_out = tag_pipe[mult_latency-1];

    // one entry per multiplier stage, moves every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            tag_pipe <= '0;
        end else begin
            tag_pipe <= {tag_pipe[mult_latency-2:0], tag_in};
        end
    end

    always_comb begin
        cdb_add.valid     = alu_bus.valid;
        cdb_add.rob_idx   = rob_idx_add;
        cdb_add.pd        = pd_add;
        cdb_add.rd        = rd_add;
        cdb_add.rd_v      = alu_bus.rd_v;
        cdb_add.inst      = decode_info_add.inst;
        cdb_add.pc_select = 1'b0;
        cdb_add.pc_branch = '0;

        cdb_mul.valid     = mul_bus.valid;
        cdb_mul.rob_idx   = tag_out.rob_idx;
        cdb_mul.pd        = tag_out.pd;
        cdb_mul.rd        = tag_out.rd;
        cdb_mul.rd_v      = mul_bus.rd_v;
        cdb_mul.inst      = tag_out.inst;
        cdb_mul.pc_select = 1'b0;
        cdb_mul.pc_branch = '0;

        cdb_br.valid      = br_bus.valid;
        cdb_br.rob_idx    = rob_idx_br;
        cdb_br.pd         = pd_br;
        cdb_br.rd         = rd_br;
        cdb_br.rd_v       = br_bus.rd_v;
        cdb_br.inst       = decode_info_br.inst;
        cdb_br.pc_select  = pc_select;
        cdb_br.pc_branch  = pc_branch;
    end

    // a redirect without its branch record would be lost by the rob
    a_redirect_needs_valid: assert property (
        @(posedge clk) disable iff (rst) pc_select |-> br_bus.valid
    );

endmodule

// File: common/fu_if.sv
`timescale 1ns/1ps

interface fu_if
    import exec_pkg::*;
();
    // toward the unit
    logic               start;
    logic [xlen-1:0]    rs1_v;
    logic [xlen-1:0]    rs2_v;
    decode_info_t       info;

    // back from the unit
    logic [xlen-1:0]    rd_v;
    logic               valid;

    modport ctrl (
        output start, rs1_v, rs2_v, info,
        input  rd_v, valid
    );

    modport unit (
        input  start, rs1_v, rs2_v, info,
        output rd_v, valid
    );

endinterface

// File: common/exec_pkg.sv
package exec_pkg;

    // datapath and tag widths
    localparam int xlen          = 32;
    localparam int inst_bits     = 32;
    localparam int rob_idx_bits  = 6;
    localparam int phys_reg_bits = 6;
    localparam int arch_reg_bits = 5;
    localparam int lsq_idx_bits  = 6;

    // multiplier pipeline depth, start to valid
    localparam int mult_latency  = 4;

    typedef enum logic [4:0] {
        // integer alu
        op_add    = 5'd0,
        op_sub    = 5'd1,
        op_and    = 5'd2,
        op_or     = 5'd3,
        op_xor    = 5'd4,
        op_slt    = 5'd5,
        op_sltu   = 5'd6,
        op_sll    = 5'd7,
        op_srl    = 5'd8,
        op_sra    = 5'd9,
        // m extension multiplies
        op_mul    = 5'd10,
        op_mulh   = 5'd11,
        op_mulhsu = 5'd12,
        op_mulhu  = 5'd13,
        // branches and jumps
        op_beq    = 5'd14,
        op_bne    = 5'd15,
        op_blt    = 5'd16,
        op_bge    = 5'd17,
        op_bltu   = 5'd18,
        op_bgeu   = 5'd19,
        op_jal    = 5'd20,
        op_jalr   = 5'd21,
        // memory
        op_load   = 5'd22,
        op_store  = 5'd23
    } exec_op_t;

    // decoded instruction handed over by issue, 102 bits
    typedef struct packed {
        exec_op_t              op;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       pc;
        logic                  use_imm;
        logic [inst_bits-1:0]  inst;
    } decode_info_t;

    // one common data bus record, 115 bits
    typedef struct packed {
        logic                      valid;
        logic [rob_idx_bits-1:0]   rob_idx;
        logic [phys_reg_bits-1:0]  pd;
        logic [arch_reg_bits-1:0]  rd;
        logic [xlen-1:0]           rd_v;
        logic [inst_bits-1:0]      inst;
        logic                      pc_select;
        logic [xlen-1:0]           pc_branch;
    } cdb_t;

endpackage
